// ==== verilog/issue_config.svh ====
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Instruction buffer sizing
//////////////////////////////////////////////////////////////////////

// Entries in the circular instruction queue
`define ISSUE_IBUF_DEPTH 32

// Head and tail pointer width, log2 of the depth
`define ISSUE_IBUF_AW 5

//////////////////////////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////////////////////////

// Architectural registers, r0 hardwired to zero
`define ISSUE_NUM_REGS 32

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // Any encoding not listed here is illegal
    typedef enum logic [5:0] {
        // Register forms
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        // Immediate forms
        OP_ADDI = 6'h11,
        OP_ORI  = 6'h14,
        OP_LUI  = 6'h18
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    // Register form, low 11 bits unused
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] unused;
    } r_fmt_t;

    // Immediate form
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;
    } i_fmt_t;

    // One instruction word, viewed either way
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        logic [31:0] raw;
    } inst_word_u;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Fetch side and buffer output
    //////////////////////////////////////////////////////////////////////

    // One word as pushed by fetch
    typedef struct packed {
        logic [31:0]         pc;
        isa_pkg::inst_word_u inst;
    } fetch_slot_t;

    // One issue lane of the buffer
    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        isa_pkg::inst_word_u inst;
    } issue_slot_t;

    //////////////////////////////////////////////////////////////////////
    // Decode and execute records
    //////////////////////////////////////////////////////////////////////

    // Decoded op, immediate already extended
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        isa_pkg::opcode_e op;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic             use_imm;
        logic [31:0]      imm;
        logic             illegal;
    } dec_op_t;

    // Execute result, also the retire report
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        we;
        logic        illegal;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module inst_buffer (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        pause_i,
    input  logic [1:0]                  fetch_en_i,
    input  pipe_pkg::fetch_slot_t [1:0] fetch_i,
    output logic                        full_o,
    output pipe_pkg::issue_slot_t [1:0] issue_o
);
    import pipe_pkg::*;

    // Queue storage, no reset
    fetch_slot_t mem [`ISSUE_IBUF_DEPTH];

    logic [`ISSUE_IBUF_AW-1:0] head;
    logic [`ISSUE_IBUF_AW-1:0] tail;
    logic [`ISSUE_IBUF_AW-1:0] head_p1;
    logic [`ISSUE_IBUF_AW-1:0] tail_p1;
    logic [`ISSUE_IBUF_AW:0]   count;
    logic [1:0]                push_n;
    logic [1:0]                pop_n;

    assign head_p1 = head + 1'b1;
    assign tail_p1 = tail + 1'b1;

    // Fewer than two free entries
    assign full_o = (count > (`ISSUE_IBUF_DEPTH - 2));

    //////////////////////////////////////////////////////////////////////
    // Push and pop amounts
    //////////////////////////////////////////////////////////////////////

    // Pushes while full are dropped
    always_comb begin
        push_n = 2'd0;
        if (!full_o) begin
            case (fetch_en_i)
                2'b11:   push_n = 2'd2;
                2'b01,
                2'b10:   push_n = 2'd1;
                default: push_n = 2'd0;
            endcase
        end
    end

    // Pause inserts bubbles, otherwise take two when two are there
    always_comb begin
        if (pause_i) begin
            pop_n = 2'd0;
        end else if (count >= 2) begin
            pop_n = 2'd2;
        end else if (count == 1) begin
            pop_n = 2'd1;
        end else begin
            pop_n = 2'd0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push_n == 2'd2) begin
            mem[tail]    <= fetch_i[0];
            mem[tail_p1] <= fetch_i[1];
        end else if (push_n == 2'd1) begin
            // Lone slot 1 lands at the tail like slot 0 would
            mem[tail] <= fetch_en_i[0] ? fetch_i[0] : fetch_i[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + (`ISSUE_IBUF_AW)'(pop_n);
            tail  <= tail + (`ISSUE_IBUF_AW)'(push_n);
            count <= count + (`ISSUE_IBUF_AW+1)'(push_n)
                           - (`ISSUE_IBUF_AW+1)'(pop_n);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        issue_o[0].pc   <= mem[head].pc;
        issue_o[0].inst <= mem[head].inst;
        issue_o[1].pc   <= mem[head_p1].pc;
        issue_o[1].inst <= mem[head_p1].inst;
        if (!rst_n_i || flush_i) begin
            issue_o[0].valid <= 1'b0;
            issue_o[1].valid <= 1'b0;
        end else begin
            issue_o[0].valid <= (pop_n != 2'd0);
            issue_o[1].valid <= (pop_n == 2'd2);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  pipe_pkg::issue_slot_t slot_i,
    output pipe_pkg::dec_op_t     op_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    dec_op_t dec;

    // rd and rs1 sit at the same bits in both formats
    always_comb begin
        dec         = '0;
        dec.valid   = slot_i.valid;
        dec.pc      = slot_i.pc;
        dec.op      = slot_i.inst.r.opcode;
        dec.rd      = slot_i.inst.r.rd;
        dec.rs1     = slot_i.inst.r.rs1;
        case (slot_i.inst.r.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                dec.rs2 = slot_i.inst.r.rs2;
            end
            OP_ADDI: begin
                dec.use_imm = 1'b1;
                dec.imm     = {{16{slot_i.inst.i.imm[15]}}, slot_i.inst.i.imm};
            end
            OP_ORI: begin
                dec.use_imm = 1'b1;
                dec.imm     = {16'h0000, slot_i.inst.i.imm};
            end
            OP_LUI: begin
                // No source register, keeps forwarding quiet
                dec.rs1     = 5'd0;
                dec.use_imm = 1'b1;
                dec.imm     = {slot_i.inst.i.imm, 16'h0000};
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        op_o <= dec;
        if (!rst_n_i || flush_i) begin
            op_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_lane_pair.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_lane_pair (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  pipe_pkg::dec_op_t [1:0] op_i,
    input  logic [3:0][31:0]        rf_rdata_i,
    output logic [3:0][4:0]         rf_raddr_o,
    output pipe_pkg::retire_t [1:0] ex_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [3:0][31:0] src;
    logic [1:0][31:0] opb;
    retire_t [1:0]    ex_nxt;

    // Previous group first, lane 1 of it is the younger
    function automatic logic [31:0] fwd_prev(
        input logic [4:0]    addr,
        input logic [31:0]   rf_val,
        input retire_t [1:0] prev
    );
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (prev[1].we && prev[1].rd == addr) begin
            val = prev[1].data;
        end else if (prev[0].we && prev[0].rd == addr) begin
            val = prev[0].data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    function automatic logic [31:0] alu_calc(
        input opcode_e     op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] res;
        case (op)
            OP_ADD, OP_ADDI: res = a + b;
            OP_SUB:          res = a - b;
            OP_AND:          res = a & b;
            OP_OR, OP_ORI:   res = a | b;
            OP_XOR:          res = a ^ b;
            OP_LUI:          res = b;
            default:         res = '0;
        endcase
        return res;
    endfunction

    // Read ports, rs1 then rs2 per lane
    assign rf_raddr_o[0] = op_i[0].rs1;
    assign rf_raddr_o[1] = op_i[0].rs2;
    assign rf_raddr_o[2] = op_i[1].rs1;
    assign rf_raddr_o[3] = op_i[1].rs2;

    //////////////////////////////////////////////////////////////////////
    // Operand select and compute
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        src[0] = fwd_prev(op_i[0].rs1, rf_rdata_i[0], ex_o);
        src[1] = fwd_prev(op_i[0].rs2, rf_rdata_i[1], ex_o);
        opb[0] = op_i[0].use_imm ? op_i[0].imm : src[1];

        ex_nxt[0].valid   = op_i[0].valid;
        ex_nxt[0].pc      = op_i[0].pc;
        ex_nxt[0].rd      = op_i[0].rd;
        ex_nxt[0].data    = alu_calc(op_i[0].op, src[0], opb[0]);
        ex_nxt[0].illegal = op_i[0].illegal;
        ex_nxt[0].we      = op_i[0].valid && !op_i[0].illegal && (op_i[0].rd != 5'd0);

        // Same-group result from lane 0 beats everything
        if (ex_nxt[0].we && op_i[0].rd == op_i[1].rs1) begin
            src[2] = ex_nxt[0].data;
        end else begin
            src[2] = fwd_prev(op_i[1].rs1, rf_rdata_i[2], ex_o);
        end
        if (ex_nxt[0].we && op_i[0].rd == op_i[1].rs2) begin
            src[3] = ex_nxt[0].data;
        end else begin
            src[3] = fwd_prev(op_i[1].rs2, rf_rdata_i[3], ex_o);
        end
        opb[1] = op_i[1].use_imm ? op_i[1].imm : src[3];

        ex_nxt[1].valid   = op_i[1].valid;
        ex_nxt[1].pc      = op_i[1].pc;
        ex_nxt[1].rd      = op_i[1].rd;
        ex_nxt[1].data    = alu_calc(op_i[1].op, src[2], opb[1]);
        ex_nxt[1].illegal = op_i[1].illegal;
        ex_nxt[1].we      = op_i[1].valid && !op_i[1].illegal && (op_i[1].rd != 5'd0);
    end

    always_ff @(posedge clk) begin
        ex_o <= ex_nxt;
        if (!rst_n_i || flush_i) begin
            ex_o[0].valid <= 1'b0;
            ex_o[0].we    <= 1'b0;
            ex_o[1].valid <= 1'b0;
            ex_o[1].we    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/result_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module result_regfile (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  pipe_pkg::retire_t [1:0] ex_i,
    input  logic [3:0][4:0]         raddr_i,
    output logic [3:0][31:0]        rdata_o,
    output pipe_pkg::retire_t [1:0] retire_o
);

    logic [31:0] regs [`ISSUE_NUM_REGS];

    //////////////////////////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////////////////////////

    // Lane 1 written last so it wins a shared rd
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ex_i[0].we && ex_i[0].rd != 5'd0) begin
                regs[ex_i[0].rd] <= ex_i[0].data;
            end
            if (ex_i[1].we && ex_i[1].rd != 5'd0) begin
                regs[ex_i[1].rd] <= ex_i[1].data;
            end
        end
    end

    // Four read ports, r0 reads zero
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == 5'd0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire report
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        retire_o <= ex_i;
        if (!rst_n_i) begin
            retire_o[0].valid <= 1'b0;
            retire_o[0].we    <= 1'b0;
            retire_o[1].valid <= 1'b0;
            retire_o[1].we    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_core (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        pause_i,
    input  logic [1:0]                  fetch_en_i,
    input  pipe_pkg::fetch_slot_t [1:0] fetch_i,
    output logic                        ibuf_full_o,
    output pipe_pkg::retire_t [1:0]     retire_o
);
    import pipe_pkg::*;

    issue_slot_t [1:0] issue;
    dec_op_t [1:0]     dec_op;
    retire_t [1:0]     ex;
    logic [3:0][4:0]   rf_raddr;
    logic [3:0][31:0]  rf_rdata;

    // Queue and issue
    inst_buffer i_inst_buffer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .pause_i    (pause_i),
        .fetch_en_i (fetch_en_i),
        .fetch_i    (fetch_i),
        .full_o     (ibuf_full_o),
        .issue_o    (issue)
    );

    // One decoder per issue lane
    inst_decoder i_inst_decoder_0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .slot_i  (issue[0]),
        .op_o    (dec_op[0])
    );

    inst_decoder i_inst_decoder_1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .slot_i  (issue[1]),
        .op_o    (dec_op[1])
    );

    alu_lane_pair i_alu_lane_pair (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .op_i       (dec_op),
        .rf_rdata_i (rf_rdata),
        .rf_raddr_o (rf_raddr),
        .ex_o       (ex)
    );

    // Writeback and retire
    result_regfile i_result_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_i     (ex),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata),
        .retire_o (retire_o)
    );

endmodule

`default_nettype wire

// ==== sim/issue_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RAND_GROUPS = 150;
    // Random groups plus directed, pause and full pushes
    localparam int MAX_PUSHES  = 2 * RAND_GROUPS + 120;

    // One word in program order with the cycle it was pushed
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] cyc;
        logic        iso;
    } pushed_t;

    logic              clk;
    logic              rst_n_i;
    logic              flush_i;
    logic              pause_i;
    logic [1:0]        fetch_en_i;
    fetch_slot_t [1:0] fetch_i;
    logic              ibuf_full_o;
    retire_t [1:0]     retire_o;

    pushed_t     exp_q[$];
    logic [31:0] shadow [`ISSUE_NUM_REGS];
    logic [31:0] cyc;
    logic [31:0] pause_cnt;
    logic [31:0] next_pc;
    integer      seed;
    int          mism_cnt;
    int          other_cnt;
    int          n_pushed;
    logic        taken;
    logic [31:0] r;

    issue_core i_issue_core (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .pause_i     (pause_i),
        .fetch_en_i  (fetch_en_i),
        .fetch_i     (fetch_i),
        .ibuf_full_o (ibuf_full_o),
        .retire_o    (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!pause_i) begin
            pause_cnt <= '0;
        end else if (pause_cnt < 100) begin
            pause_cnt <= pause_cnt + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Concurrent checks
    //////////////////////////////////////////////////////////////////////

    // Three groups past the buffer may still drain after pause
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pause_cnt >= 4 && (retire_o[0].valid || retire_o[1].valid)))
    else begin
        other_cnt++;
        $display("retire seen after issue was paused for %0d cycles", pause_cnt);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) flush_i |=> !ibuf_full_o)
    else begin
        other_cnt++;
        $display("buffer still full one cycle after a flush");
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and retire monitor
    //////////////////////////////////////////////////////////////////////

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            mism_cnt++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Executes the oldest pushed word on the shadow registers
    task automatic check_retire(input retire_t got);
        pushed_t     ent;
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        bad;
        logic        we;
        if (exp_q.size() == 0) begin
            other_cnt++;
            $display("retire at pc %h with no instruction outstanding", got.pc);
        end else begin
            ent = exp_q.pop_front();
            op  = ent.word[31:26];
            rd  = ent.word[25:21];
            a   = shadow[ent.word[20:16]];
            b   = shadow[ent.word[15:11]];
            bad = 1'b0;
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + {{16{ent.word[15]}}, ent.word[15:0]};
                OP_ORI:  res = a | {16'h0000, ent.word[15:0]};
                OP_LUI:  res = {ent.word[15:0], 16'h0000};
                default: begin
                    res = '0;
                    bad = 1'b1;
                end
            endcase
            we = !bad && (rd != 5'd0);
            expect_eq("retire_o.pc", got.pc, ent.pc);
            expect_eq("retire_o.rd", 32'(got.rd), 32'(rd));
            expect_eq("retire_o.we", 32'(got.we), 32'(we));
            expect_eq("retire_o.illegal", 32'(got.illegal), 32'(bad));
            if (!bad) begin
                expect_eq("retire_o.data", got.data, res);
            end
            if (ent.iso) begin
                expect_eq("push to retire latency", cyc - ent.cyc - 1, 32'd4);
            end
            if (we) begin
                shadow[rd] = res;
            end
        end
    endtask

    // Lane 0 is the older one
    always @(negedge clk) begin
        if (rst_n_i) begin
            for (int l = 0; l < 2; l++) begin
                if (retire_o[l].valid) begin
                    check_retire(retire_o[l]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic logic [31:0] reg_word(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {op, rd, rs1, rs2, 11'h000};
    endfunction

    // Legal opcode on r0..r7 so dependencies are frequent
    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        logic [5:0]  op;
        v = $random(seed);
        case (v[2:0])
            3'd0:    op = OP_ADD;
            3'd1:    op = OP_SUB;
            3'd2:    op = OP_AND;
            3'd3:    op = OP_OR;
            3'd4:    op = OP_XOR;
            3'd5:    op = OP_ADDI;
            3'd6:    op = OP_ORI;
            default: op = OP_LUI;
        endcase
        if (v[2:0] < 3'd5) begin
            return reg_word(op, {2'b00, v[5:3]}, {2'b00, v[8:6]}, {2'b00, v[11:9]});
        end
        return imm_word(op, {2'b00, v[5:3]}, {2'b00, v[8:6]}, v[31:16]);
    endfunction

    // One fetch cycle with no push while the buffer is full
    task automatic push_cycle(input logic [1:0] en, input logic [31:0] w0,
                              input logic [31:0] w1, input logic iso, output logic ok);
        pushed_t    ent;
        logic [1:0] use_en;
        @(negedge clk);
        use_en = ibuf_full_o ? 2'b00 : en;
        fetch_en_i          = use_en;
        fetch_i[0].pc       = next_pc;
        fetch_i[0].inst.raw = w0;
        fetch_i[1].pc       = next_pc + 4;
        fetch_i[1].inst.raw = w1;
        ent.cyc = cyc;
        ent.iso = iso;
        for (int s = 0; s < 2; s++) begin
            if (use_en[s]) begin
                ent.pc   = fetch_i[s].pc;
                ent.word = s ? w1 : w0;
                exp_q.push_back(ent);
            end
        end
        next_pc = next_pc + 8;
        ok = (use_en != 2'b00);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        fetch_en_i = 2'b00;
        @(posedge clk);
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            other_cnt++;
            $display("%0d pushed instructions never retired", exp_q.size());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed       = 32'hb297;
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        pause_i    = 1'b0;
        fetch_en_i = 2'b00;
        fetch_i    = '0;
        cyc        = '0;
        pause_cnt  = '0;
        next_pc    = 32'h0000_1000;
        mism_cnt   = 0;
        other_cnt  = 0;
        for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        // Idle after reset
        repeat (20) begin
            @(negedge clk);
            assert (!retire_o[0].valid && !retire_o[1].valid && !ibuf_full_o) else begin
                other_cnt++;
                $display("retire valid or buffer full while idle after reset");
            end
        end

        // Isolated pushes on either slot and then dependent groups
        push_cycle(2'b01, imm_word(OP_ADDI, 5'd1, 5'd0, 16'h8123), '0, 1'b1, taken);
        wait_drain(20);
        push_cycle(2'b10, '0, imm_word(OP_ORI, 5'd2, 5'd1, 16'hf00f), 1'b1, taken);
        wait_drain(20);
        push_cycle(2'b11, imm_word(OP_LUI, 5'd3, 5'd0, 16'h1234),
                   reg_word(OP_ADD, 5'd4, 5'd3, 5'd3), 1'b0, taken);
        push_cycle(2'b11, reg_word(OP_SUB, 5'd5, 5'd4, 5'd1),
                   reg_word(OP_XOR, 5'd6, 5'd5, 5'd4), 1'b0, taken);
        push_cycle(2'b11, reg_word(OP_AND, 5'd7, 5'd6, 5'd2),
                   reg_word(OP_OR, 5'd1, 5'd7, 5'd5), 1'b0, taken);
        for (int g = 0; g < RAND_GROUPS; g++) begin
            r = $random(seed);
            push_cycle(r[1:0], rand_word(), rand_word(), 1'b0, taken);
        end
        wait_drain(60);

        // Illegal opcodes leave the registers alone
        push_cycle(2'b11, imm_word(6'h3f, 5'd2, 5'd1, 16'h0001),
                   reg_word(OP_ADD, 5'd7, 5'd2, 5'd2), 1'b0, taken);
        push_cycle(2'b01, reg_word(6'h00, 5'd3, 5'd1, 5'd1), '0, 1'b0, taken);
        push_cycle(2'b01, reg_word(OP_OR, 5'd6, 5'd3, 5'd0), '0, 1'b0, taken);
        wait_drain(30);

        // Pause while fetch keeps pushing
        for (int g = 0; g < 22; g++) begin
            push_cycle(2'b11, rand_word(), rand_word(), 1'b0, taken);
            if (g == 4) begin
                pause_i = 1'b1;
            end else if (g == 15) begin
                pause_i = 1'b0;
            end
        end
        wait_drain(60);

        // Fill the paused buffer and flush it with groups in flight
        @(negedge clk);
        pause_i  = 1'b1;
        n_pushed = 0;
        for (int g = 0; g < `ISSUE_IBUF_DEPTH; g++) begin
            push_cycle(2'b11, rand_word(), rand_word(), 1'b0, taken);
            if (taken) begin
                n_pushed += 2;
            end
        end
        @(negedge clk);
        fetch_en_i = 2'b00;
        assert (ibuf_full_o && n_pushed <= `ISSUE_IBUF_DEPTH) else begin
            other_cnt++;
            $display("buffer not full after %0d pushes with issue paused", n_pushed);
        end
        // Two groups reach decode and issue before the flush edge
        pause_i = 1'b0;
        repeat (2) @(negedge clk);
        flush_i = 1'b1;
        exp_q.delete();
        @(negedge clk);
        flush_i = 1'b0;
        repeat (10) @(negedge clk);
        for (int g = 0; g < 8; g++) begin
            push_cycle(2'b11, rand_word(), rand_word(), 1'b0, taken);
        end
        wait_drain(40);

        // r0 stays zero and lane 1 wins a shared rd
        push_cycle(2'b11, imm_word(OP_ADDI, 5'd0, 5'd0, 16'h0055),
                   reg_word(OP_ADD, 5'd1, 5'd0, 5'd0), 1'b0, taken);
        push_cycle(2'b11, imm_word(OP_ADDI, 5'd3, 5'd0, 16'h0011),
                   imm_word(OP_ADDI, 5'd3, 5'd0, 16'h0022), 1'b0, taken);
        push_cycle(2'b11, reg_word(OP_ADD, 5'd4, 5'd3, 5'd0),
                   reg_word(OP_OR, 5'd5, 5'd3, 5'd3), 1'b0, taken);
        wait_drain(20);
        push_cycle(2'b01, reg_word(OP_ADD, 5'd6, 5'd3, 5'd0), '0, 1'b0, taken);
        wait_drain(20);

        $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (MAX_PUSHES * 10 + 200) @(posedge clk);
        $display("watchdog expired after %0d cycles", MAX_PUSHES * 10 + 200);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_core.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_buffer.sv
verilog/inst_decoder.sv
verilog/alu_lane_pair.sv
verilog/result_regfile.sv
verilog/issue_core.sv
sim/issue_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the issue_core testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb \
    -f issue_core.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vissue_core_tb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
exit 0
